// ==== core_backend.f ====
+incdir+common
common/core_pkg.sv
design/pipe_reg.sv
design/regfile.sv
design/hazard_ctrl.sv
execute/mul_timer.sv
execute/exec_alu.sv
design/core_backend.sv
verification/core_backend_chk.sv
verification/core_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f core_backend.f \
    --top-module core_backend_tb -o core_backend_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/core_backend_sim +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

// ==== verification/core_backend_tb.sv ====
`default_nettype none

`include "core_params.svh"

module core_backend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES = 16 + 64 * 8 + 32;   // reset, instructions, drain.

    logic                     clk = 1'b0;
    logic                     rst_n;
    core_pkg::issue_t         issue;
    logic                     ready;
    logic                     redirect;
    logic [`CORE_PC_BITS-1:0] redirect_pc;
    core_pkg::wb_t            wb;

    logic [`CORE_XLEN-1:0]    shadow [`CORE_NUM_REGS];
    logic [4:0]               exp_rd [$];
    logic [`CORE_XLEN-1:0]    exp_data [$];
    logic [`CORE_PC_BITS-1:0] pc;
    int                       seed = 32'h6240_ad95;
    int                       errors = 0;
    int                       stall_cycles;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    int                       test_start;

    core_backend i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .ready       (ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

    always #20 clk = ~clk;

    function automatic int error_total();
        return errors + i_dut.u_chk.fails;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("MISMATCH %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_total() != test_start) begin
            tests_failed++;
        end
        $display("test %s %s", name, (error_total() == test_start) ? "ok" : "failed");
        test_start = error_total();
    endtask

    // reference result from the operation rules.
    function automatic logic [31:0] model(input core_pkg::alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b, input logic use_imm,
                                          input logic [15:0] imm, input logic [4:0] shamt);
        logic [31:0] y;
        y = use_imm ? {{16{imm[15]}}, imm} : b;
        case (op)
            core_pkg::op_add: return a + y;
            core_pkg::op_sub: return a - y;
            core_pkg::op_and: return a & y;
            core_pkg::op_or:  return a | y;
            core_pkg::op_xor: return a ^ y;
            core_pkg::op_slt: return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
            core_pkg::op_sll: return y << shamt;
            core_pkg::op_srl: return y >> shamt;
            core_pkg::op_lui: return {imm, 16'h0000};
            core_pkg::op_mul: return a * y;
            default:          return 32'd0;
        endcase
    endfunction

    // holds the instruction on issue until the DUT takes it.
    task automatic present(input core_pkg::issue_t ins);
        int waits;
        waits = 0;
        issue = ins;
        issue.valid = 1'b1;
        @(negedge clk);
        while (!ready && waits < 32) begin
            waits++;
            @(negedge clk);
        end
        if (!ready) begin
            $display("ERROR: instruction at pc %h was never accepted", ins.pc_4);
            errors++;
        end
        stall_cycles = waits;
        @(posedge clk);
        #2;
        issue.valid = 1'b0;
        pc = pc + 30'd1;
    endtask

    task automatic send(input core_pkg::alu_op_e op, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt, input logic use_imm, input logic [15:0] imm);
        core_pkg::issue_t ins;
        logic [31:0]      r;
        logic [4:0]       shamt;
        shamt = 5'($random(seed));
        ins = '0;
        ins.pc_4 = pc + 30'd1;
        ins.pc_guessed = pc + 30'd1;
        ins.rs = rs;
        ins.rt = rt;
        ins.rd = rd;
        ins.shamt = shamt;
        ins.imm16 = imm;
        ins.alu_op = op;
        ins.use_imm = use_imm;
        ins.wb_en = 1'b1;
        r = model(op, shadow[rs], shadow[rt], use_imm, imm, shamt);
        exp_rd.push_back(rd);
        exp_data.push_back(r);
        if (rd != 5'd0) begin
            shadow[rd] = r;
        end
        present(ins);
    endtask

    task automatic branch(input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] off,
                          input logic guess_taken);
        core_pkg::issue_t         ins;
        logic [`CORE_PC_BITS-1:0] taken_pc;
        logic [`CORE_PC_BITS-1:0] actual;
        logic [`CORE_PC_BITS-1:0] guessed;
        taken_pc = pc + 30'd1 + {{14{off[15]}}, off};
        actual = (shadow[rs] == shadow[rt]) ? taken_pc : pc + 30'd1;
        guessed = guess_taken ? taken_pc : pc + 30'd1;
        ins = '0;
        ins.pc_4 = pc + 30'd1;
        ins.pc_guessed = guessed;
        ins.rs = rs;
        ins.rt = rt;
        ins.imm16 = off;
        ins.alu_op = core_pkg::op_beq;
        ins.wb_en = 1'b1;                                // a branch still writes nothing.
        present(ins);                                    // returns with the branch in execute.
        check_value("redirect", {31'd0, actual != guessed}, {31'd0, redirect});
        if (actual != guessed) begin
            check_value("redirect_pc", {2'b00, actual}, {2'b00, redirect_pc});
        end
    endtask

    // ----------------------------------------
    // write-back scoreboard
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            if (exp_rd.size() == 0) begin
                $display("ERROR: write-back to r%0d with nothing outstanding", wb.rd);
                errors++;
            end else begin
                check_value("wb.rd", {27'd0, exp_rd.pop_front()}, {27'd0, wb.rd});
                check_value("wb.data", exp_data.pop_front(), wb.data);
            end
        end
    end

    initial begin
        #(RUN_CYCLES * 40);
        $display("ERROR: watchdog expired after %0d cycles", RUN_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        core_pkg::alu_op_e ops [9];
        ops = '{core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
                core_pkg::op_xor, core_pkg::op_slt, core_pkg::op_sll, core_pkg::op_srl,
                core_pkg::op_lui};
        issue = '0;
        rst_n = 1'b0;
        pc = '0;
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        test_start = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ready", 32'd1, {31'd0, ready});
        check_value("wb.valid", 32'd0, {31'd0, wb.valid});
        check_value("redirect", 32'd0, {31'd0, redirect});
        finish_test("reset");
        @(posedge clk);
        #2;

        for (int r = 1; r <= 8; r++) begin
            send(core_pkg::op_lui, 5'(r), 5'd0, 5'd0, 1'b1, 16'($random(seed)));
            send(core_pkg::op_or, 5'(r), 5'(r), 5'd0, 1'b1, 16'($random(seed)));
        end
        send(core_pkg::op_add, 5'd4, 5'd3, 5'd0, 1'b0, 16'd0);    // r4 equals r3 for beq.
        send(core_pkg::op_add, 5'd0, 5'd1, 5'd2, 1'b0, 16'd0);
        for (int i = 0; i < 9; i++) begin
            send(ops[i], 5'(10 + i), 5'(1 + i % 8), 5'(1 + (i + 3) % 8), 1'b0, 16'($random(seed)));
            send(ops[i], 5'(19 + i), 5'(1 + (i + 5) % 8), 5'd0, 1'b1, 16'($random(seed)));
        end
        send(core_pkg::op_or, 5'd28, 5'd0, 5'd0, 1'b1, 16'h1234);
        finish_test("alu");

        send(core_pkg::op_add, 5'd20, 5'd1, 5'd2, 1'b0, 16'd0);
        send(core_pkg::op_sub, 5'd21, 5'd20, 5'd3, 1'b0, 16'd0);
        check_value("ready_stall_cycles", 32'd1, stall_cycles);
        send(core_pkg::op_xor, 5'd22, 5'd5, 5'd21, 1'b0, 16'd0);
        check_value("ready_stall_cycles", 32'd1, stall_cycles);
        finish_test("raw");

        send(core_pkg::op_mul, 5'd23, 5'd1, 5'd2, 1'b0, 16'd0);
        send(core_pkg::op_add, 5'd24, 5'd5, 5'd6, 1'b0, 16'd0);
        check_value("ready_stall_cycles", `CORE_MUL_CYCLES, stall_cycles);
        send(core_pkg::op_mul, 5'd25, 5'd3, 5'd0, 1'b1, 16'($random(seed)));
        send(core_pkg::op_or, 5'd26, 5'd7, 5'd8, 1'b0, 16'd0);
        check_value("ready_stall_cycles", `CORE_MUL_CYCLES, stall_cycles);
        finish_test("mul");

        branch(5'd3, 5'd4, 16'hfff0, 1'b0);              // taken, guessed not taken.
        branch(5'd1, 5'd2, 16'h0040, 1'b1);              // not taken, guessed taken.
        branch(5'd3, 5'd4, 16'h0008, 1'b1);
        branch(5'd1, 5'd2, 16'h0008, 1'b0);
        send(core_pkg::op_add, 5'd27, 5'd1, 5'd4, 1'b0, 16'd0);
        finish_test("branch");

        repeat (8) begin
            if (exp_rd.size() != 0) begin
                @(posedge clk);
            end
        end
        if (exp_rd.size() != 0) begin
            $display("ERROR: %0d write-backs never arrived", exp_rd.size());
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
        if (error_total() == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/core_backend_chk.sv ====
`default_nettype none

`include "core_params.svh"

module core_backend_chk (
    input logic             clk,
    input logic             rst_n,
    input core_pkg::issue_t issue,
    input logic             ready,
    input logic             redirect,
    input core_pkg::wb_t    wb,
    input core_pkg::id_ex_t id_ex_q,
    input logic             is_mul
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fails = 0;
    logic accept;
    logic single_op;
    logic raw_stall;

    assign accept    = issue.valid && ready;
    assign single_op = (issue.alu_op != core_pkg::op_mul) && (issue.alu_op != core_pkg::op_beq);
    assign raw_stall = issue.valid && id_ex_q.valid && id_ex_q.wb_en && !is_mul &&
                       (((issue.rs != '0) && (issue.rs == id_ex_q.rd)) ||
                        ((issue.rt != '0) && (issue.rt == id_ex_q.rd)));

    // ----------------------------------------
    // reset and issue timing
    // ----------------------------------------
    a_reset: assert property (@(posedge clk) !rst_n |-> ready && !wb.valid && !redirect)
        else begin $error("outputs not idle in reset"); fails++; end

    a_single_wb: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept && issue.wb_en && single_op, 2) |-> wb.valid && (wb.rd == $past(issue.rd, 2)))
        else begin $error("single-cycle write-back late or missing"); fails++; end

    a_raw_stall: assert property (@(posedge clk) disable iff (!rst_n) raw_stall |-> !ready)
        else begin $error("dependent instruction accepted"); fails++; end

    a_raw_once: assert property (@(posedge clk) disable iff (!rst_n) $past(raw_stall) |-> ready)
        else begin $error("dependency stall longer than one cycle"); fails++; end

    // ----------------------------------------
    // multiply and branch
    // ----------------------------------------
    a_mul_wait: assert property (@(posedge clk) disable iff (!rst_n) is_mul |-> !ready)
        else begin $error("issue open during multiply"); fails++; end

    a_mul_wb: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept && issue.wb_en && (issue.alu_op == core_pkg::op_mul), `CORE_MUL_CYCLES + 1)
        |-> wb.valid && (wb.rd == $past(issue.rd, `CORE_MUL_CYCLES + 1)))
        else begin $error("multiply write-back late or missing"); fails++; end

    a_redirect_once: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else begin $error("redirect held past the branch cycle"); fails++; end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n) $past(redirect) |-> !ready)
        else begin $error("issue open in flush cycle"); fails++; end

    a_beq_silent: assert property (@(posedge clk) disable iff (!rst_n)
        $past(id_ex_q.valid && (id_ex_q.alu_op == core_pkg::op_beq)) |-> !wb.valid)
        else begin $error("branch produced a write-back"); fails++; end

endmodule

bind core_backend core_backend_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .ready    (ready),
    .redirect (redirect),
    .wb       (wb),
    .id_ex_q  (id_ex_q),
    .is_mul   (is_mul)
);

`default_nettype wire

// ==== design/core_backend.sv ====
`default_nettype none

`include "core_params.svh"

module core_backend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::issue_t         issue,
    output logic                     ready,
    output logic                     redirect,
    output logic [`CORE_PC_BITS-1:0] redirect_pc,
    output core_pkg::wb_t            wb
);

    logic [`CORE_XLEN-1:0] rs_data;
    logic [`CORE_XLEN-1:0] rt_data;
    core_pkg::id_ex_t      id_ex_d;
    core_pkg::id_ex_t      id_ex_q;
    core_pkg::ex_wb_t      ex_wb_d;
    core_pkg::ex_wb_t      ex_wb_q;
    logic                  id_ex_en;
    logic                  id_ex_clear;
    logic                  ex_wb_clear;
    logic                  is_mul;
    logic                  mul_last;

    // ----------------------------------------
    // issue and operand read
    // ----------------------------------------
    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (issue.rs),
        .rt_addr (issue.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    assign id_ex_d = '{
        valid:      issue.valid && ready,        // only an accepted instruction enters.
        pc_4:       issue.pc_4,
        pc_guessed: issue.pc_guessed,
        rt:         issue.rt,
        rd:         issue.rd,
        shamt:      issue.shamt,
        imm16:      issue.imm16,
        alu_op:     issue.alu_op,
        use_imm:    issue.use_imm,
        wb_en:      issue.wb_en,
        data_a:     rs_data,
        data_b:     rt_data
    };

    pipe_reg #(.payload_t(core_pkg::id_ex_t)) id_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (id_ex_en),
        .clear (id_ex_clear),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // ----------------------------------------
    // execute
    // ----------------------------------------
    exec_alu u_exec_alu (
        .ex          (id_ex_q),
        .res         (ex_wb_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .is_mul      (is_mul)
    );

    mul_timer u_mul_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (is_mul),
        .mul_last (mul_last)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .ex_rd       (id_ex_q.rd),
        .ex_wb_en    (id_ex_q.wb_en),
        .ex_valid    (id_ex_q.valid),
        .ex_mul      (is_mul),
        .mul_last    (mul_last),
        .redirect    (redirect),
        .ready       (ready),
        .id_ex_en    (id_ex_en),
        .id_ex_clear (id_ex_clear),
        .ex_wb_clear (ex_wb_clear)
    );

    // ----------------------------------------
    // write-back
    // ----------------------------------------
    pipe_reg #(.payload_t(core_pkg::ex_wb_t)) ex_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),                           // write-back is never stalled.
        .clear (ex_wb_clear),
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    assign wb = '{
        valid: ex_wb_q.valid && ex_wb_q.wb_en,
        rd:    ex_wb_q.rd,
        data:  ex_wb_q.result
    };

endmodule

`default_nettype wire

// ==== execute/exec_alu.sv ====
`default_nettype none

`include "core_params.svh"

module exec_alu (
    input  core_pkg::id_ex_t         ex,
    output core_pkg::ex_wb_t         res,
    output logic                     redirect,
    output logic [`CORE_PC_BITS-1:0] redirect_pc,
    output logic                     is_mul
);

    localparam int unsigned XLEN    = `CORE_XLEN;
    localparam int unsigned PC_BITS = `CORE_PC_BITS;

    logic [XLEN-1:0]    imm_sext;
    logic [XLEN-1:0]    y;
    logic [XLEN-1:0]    result;
    logic [PC_BITS-1:0] branch_off;
    logic [PC_BITS-1:0] next_pc;
    logic               is_beq;
    logic               equal;

    assign imm_sext = {{(XLEN - 16){ex.imm16[15]}}, ex.imm16};
    assign y        = ex.use_imm ? imm_sext : ex.data_b;

    // ----------------------------------------
    // result
    // ----------------------------------------
    always_comb begin
        case (ex.alu_op)
            core_pkg::op_add: result = ex.data_a + y;
            core_pkg::op_sub: result = ex.data_a - y;
            core_pkg::op_and: result = ex.data_a & y;
            core_pkg::op_or:  result = ex.data_a | y;
            core_pkg::op_xor: result = ex.data_a ^ y;
            core_pkg::op_slt: result = XLEN'($signed(ex.data_a) < $signed(y));
            core_pkg::op_sll: result = y << ex.shamt;
            core_pkg::op_srl: result = y >> ex.shamt;
            core_pkg::op_lui: result = {ex.imm16, 16'h0000};
            core_pkg::op_mul: result = ex.data_a * y;   // the low word of the product.
            default:          result = '0;
        endcase
    end

    assign is_mul = ex.valid && (ex.alu_op == core_pkg::op_mul);
    assign is_beq = ex.valid && (ex.alu_op == core_pkg::op_beq);

    assign res = '{
        valid:  ex.valid,
        wb_en:  ex.wb_en && !is_beq,             // a branch never writes back.
        rd:     ex.rd,
        result: result
    };

    // ----------------------------------------
    // branch resolution
    // ----------------------------------------
    // beq always compares the two registers, even when use_imm is set.
    assign equal      = (ex.data_a == ex.data_b);
    assign branch_off = {{(PC_BITS - 16){ex.imm16[15]}}, ex.imm16};
    assign next_pc    = equal ? (ex.pc_4 + branch_off) : ex.pc_4;

    assign redirect    = is_beq && (next_pc != ex.pc_guessed);
    assign redirect_pc = next_pc;

endmodule

`default_nettype wire

// ==== execute/mul_timer.sv ====
`default_nettype none

`include "core_params.svh"

module mul_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic mul_last
);

    localparam int unsigned CYCLES = `CORE_MUL_CYCLES;
    localparam int unsigned CNT_W  = (CYCLES > 1) ? $clog2(CYCLES) : 1;

    logic [CNT_W-1:0] count;
    logic             busy;
    logic             launch;

    assign launch = start && !busy;              // first cycle of a multiply in id/ex.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (launch && (CYCLES > 1)) begin
            busy  <= 1'b1;
            count <= CNT_W'(CYCLES - 1);
        end else if (busy) begin
            count <= count - 1'b1;
            if (count == CNT_W'(1)) begin
                busy <= 1'b0;                    // this decrement reaches zero.
            end
        end
    end

    // the last cycle is the one whose decrement takes the count to zero.
    assign mul_last = (CYCLES == 1) ? launch : (busy && (count == CNT_W'(1)));

endmodule

`default_nettype wire

// ==== design/hazard_ctrl.sv ====
`default_nettype none

`include "core_params.svh"

module hazard_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  core_pkg::issue_t               issue,
    input  logic [`CORE_REG_ADDR_BITS-1:0] ex_rd,
    input  logic                           ex_wb_en,
    input  logic                           ex_valid,
    input  logic                           ex_mul,
    input  logic                           mul_last,
    input  logic                           redirect,
    output logic                           ready,
    output logic                           id_ex_en,
    output logic                           id_ex_clear,
    output logic                           ex_wb_clear
);

    typedef enum logic [1:0] {
        st_run,
        st_mul_wait,
        st_flush
    } state_e;

    state_e state;
    state_e state_next;
    logic   mul_hold;
    logic   rs_hit;
    logic   rt_hit;
    logic   raw_hit;

    assign mul_hold = ex_mul && !mul_last;       // multiply still needs id/ex.
    assign rs_hit   = (issue.rs != '0) && (issue.rs == ex_rd);
    assign rt_hit   = (issue.rt != '0) && (issue.rt == ex_rd);
    assign raw_hit  = issue.valid && ex_valid && ex_wb_en && (rs_hit || rt_hit);

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (redirect) begin
                    state_next = st_flush;
                end else if (mul_hold) begin
                    state_next = st_mul_wait;
                end
            end
            st_mul_wait: begin
                if (mul_last) begin
                    state_next = st_run;
                end
            end
            st_flush: state_next = st_run;        // a single flush cycle.
            default:  state_next = st_run;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // pipeline controls
    // ----------------------------------------
    // a dependent instruction waits one cycle and then picks up the result through the bypass.
    assign ready       = (state == st_run) && !mul_hold && !raw_hit && !redirect;
    assign id_ex_en    = !mul_hold;
    assign id_ex_clear = (state == st_flush);
    assign ex_wb_clear = mul_hold || (state == st_flush); // partial products never reach wb.

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`default_nettype none

`include "core_params.svh"

module regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`CORE_REG_ADDR_BITS-1:0] rs_addr,
    input  logic [`CORE_REG_ADDR_BITS-1:0] rt_addr,
    output logic [`CORE_XLEN-1:0]          rs_data,
    output logic [`CORE_XLEN-1:0]          rt_data,
    input  core_pkg::wb_t                  wb
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];
    logic                  wr_live;

    assign wr_live = wb.valid && (wb.rd != '0);  // register zero never takes a write.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // ----------------------------------------
    // read ports with write bypass
    // ----------------------------------------
    always_comb begin
        if (rs_addr == '0) begin
            rs_data = '0;
        end else if (wr_live && (wb.rd == rs_addr)) begin
            rs_data = wb.data;                   // same-cycle write is seen by the reader.
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (rt_addr == '0) begin
            rt_data = '0;
        end else if (wr_live && (wb.rd == rt_addr)) begin
            rt_data = wb.data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload has valid low, so reset and clear both leave a bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;                       // clear wins over enable.
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== common/core_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package core_pkg;

    // ----------------------------------------
    // operation codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_slt = 4'd5,
        op_sll = 4'd6,
        op_srl = 4'd7,
        op_lui = 4'd8,
        op_mul = 4'd9,
        op_beq = 4'd10
    } alu_op_e;

    // ----------------------------------------
    // stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic                              valid;
        logic [`CORE_PC_BITS-1:0]          pc_4;       // address of the next instruction.
        logic [`CORE_PC_BITS-1:0]          pc_guessed; // front end prediction.
        logic [`CORE_REG_ADDR_BITS-1:0]    rs;
        logic [`CORE_REG_ADDR_BITS-1:0]    rt;
        logic [`CORE_REG_ADDR_BITS-1:0]    rd;
        logic [$clog2(`CORE_XLEN)-1:0]     shamt;
        logic [15:0]                       imm16;
        alu_op_e                           alu_op;
        logic                              use_imm;    // immediate replaces data_b as y.
        logic                              wb_en;
    } issue_t;

    typedef struct packed {
        logic                              valid;
        logic [`CORE_PC_BITS-1:0]          pc_4;
        logic [`CORE_PC_BITS-1:0]          pc_guessed;
        logic [`CORE_REG_ADDR_BITS-1:0]    rt;
        logic [`CORE_REG_ADDR_BITS-1:0]    rd;
        logic [$clog2(`CORE_XLEN)-1:0]     shamt;
        logic [15:0]                       imm16;
        alu_op_e                           alu_op;
        logic                              use_imm;
        logic                              wb_en;
        logic [`CORE_XLEN-1:0]             data_a;     // value of rs at issue.
        logic [`CORE_XLEN-1:0]             data_b;     // value of rt at issue.
    } id_ex_t;

    typedef struct packed {
        logic                              valid;
        logic                              wb_en;
        logic [`CORE_REG_ADDR_BITS-1:0]    rd;
        logic [`CORE_XLEN-1:0]             result;
    } ex_wb_t;

    // what the register file write port and the outside both see.
    typedef struct packed {
        logic                              valid;
        logic [`CORE_REG_ADDR_BITS-1:0]    rd;
        logic [`CORE_XLEN-1:0]             data;
    } wb_t;

endpackage

`default_nettype wire

// ==== common/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ----------------------------------------
// datapath
// ----------------------------------------
`define CORE_XLEN          32

// the pc counts words, so two address bits are never carried.
`define CORE_PC_BITS       30

`define CORE_REG_ADDR_BITS 5
`define CORE_NUM_REGS      32

// ----------------------------------------
// execute timing
// ----------------------------------------
// number of cycles a multiply occupies the id/ex register.
`define CORE_MUL_CYCLES    4

`endif
